/* files.f */
source/qla_pkg.sv
source/reg_bus_port.sv
source/board_regs.sv
source/dac_regs.sv
source/safety_check.sv
source/qla_ctrl_top.sv
testbench/tb_qla_ctrl.sv

/* Bender.yml */
package:
  name: qla_ctrl

sources:
  - source/qla_pkg.sv
  - source/reg_bus_port.sv
  - source/board_regs.sv
  - source/dac_regs.sv
  - source/safety_check.sv
  - source/qla_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_qla_ctrl.sv

/* testbench/tb_qla_ctrl.sv */
// --------------------------------------
// self-checking testbench for the register-bus side of the
// motor controller. applies a table of bus accesses in a loop
// and then a directed overcurrent trip and clear on axis 2
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_qla_ctrl import qla_pkg::*;;

    localparam int         wait_limit  = 100;        // cycles per wait loop
    localparam logic [3:0] board_wenid = 4'b0110;    // rotary switch setting

    logic       sysclk = 1'b0;
    logic       rst_n;
    logic       req_valid;
    bus_req_t   req;
    logic       req_ready;
    logic       resp_valid;
    reg_data_t  resp_rdata;
    logic       resp_ready;
    logic [3:0] wenid;
    cur_vec_t   cur_fb;
    cur_vec_t   cur_cmd;
    axis_bits_t amp_disable;
    logic       pwr_enable;
    logic [3:0] dout;

    integer   seed;
    cur_vec_t cmd_exp;                                // expected command per axis

    // stimulus table with one slot per access
    string     names[$];
    logic      wr_q[$];
    reg_addr_t addr_q[$];
    reg_data_t wdata_q[$];
    cur_vec_t  fb_q[$];
    reg_data_t exp_q[$];

    always #20 sysclk = ~sysclk;                      // 40 ns period

    qla_ctrl_top qla_ctrl_top_i (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .resp_ready  (resp_ready),
        .wenid       (wenid),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable),
        .dout        (dout)
    );

    // --------------------------------------
    // helpers
    // --------------------------------------
    task automatic next_cycle();
        @(posedge sysclk);
        #2;                                           // drive and sample point
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run($sformatf("check %s did not match", name));
        end
    endtask

    function automatic reg_addr_t make_addr(input int chan, input logic [3:0] off);
        return {8'h00, chan[3:0], off};
    endfunction

    // board status word with id, power, trips and enables
    function automatic reg_data_t status_word(input logic pwr, input logic [3:0] trips,
                                              input logic [3:0] en);
        return {4'h0, ~board_wenid, 4'h0, pwr, 7'h00, trips, 4'h0, en};
    endfunction

    task automatic add_entry(input string name, input logic wr_flag, input reg_addr_t addr,
                             input reg_data_t data, input cur_vec_t fb,
                             input reg_data_t expected);
        names.push_back(name);
        wr_q.push_back(wr_flag);
        addr_q.push_back(addr);
        wdata_q.push_back(data);
        fb_q.push_back(fb);
        exp_q.push_back(expected);
    endtask

    task automatic send_request(input logic wr_flag, input reg_addr_t addr,
                                input reg_data_t data);
        int cnt;
        cnt = 0;
        req.write = wr_flag;
        req.addr  = addr;
        req.wdata = data;
        req_valid = 1'b1;
        while (!req_ready) begin
            next_cycle();
            cnt++;
            if (cnt > wait_limit)
                abort_run("request never accepted, req_ready stayed low");
        end
        next_cycle();                                 // transfer edge
        req_valid = 1'b0;
    endtask

    // waits for the response and back-pressures 0 to 3 cycles
    task automatic get_response(output reg_data_t rdata);
        int        cnt;
        int        hold;
        reg_data_t held;
        cnt = 0;
        while (!resp_valid) begin
            next_cycle();
            cnt++;
            if (cnt > wait_limit)
                abort_run("no response, resp_valid never rose");
        end
        held = resp_rdata;
        hold = $unsigned($random(seed)) % 4;
        for (int i = 0; i < hold; i++) begin
            next_cycle();
            check_value("stall_resp_valid", 1, resp_valid);
            check_value("stall_resp_rdata", held, resp_rdata);
            check_value("stall_req_ready", 0, req_ready);
        end
        resp_ready = 1'b1;
        next_cycle();                                 // handshake edge
        resp_ready = 1'b0;
        check_value("resp_valid_drop", 0, resp_valid);
        rdata = held;
    endtask

    task automatic run_access(input string name, input logic wr_flag, input reg_addr_t addr,
                              input reg_data_t data, input reg_data_t expected);
        reg_data_t rdata;
        send_request(wr_flag, addr, data);
        get_response(rdata);
        check_value(name, expected, rdata);
    endtask

    // outputs that a write must have changed with no trips pending
    task automatic check_write_effect(input string name, input reg_addr_t addr,
                                      input reg_data_t data);
        int         chan;
        logic [3:0] exp_dis;
        chan    = addr[7:4];
        exp_dis = ~data[3:0] | {4{~data[19]}};
        if (chan >= 1 && chan <= num_axes && addr[3:0] == off_dac_ctrl) begin
            cmd_exp[chan] = data[15:0];               // only this slot moves
            check_value({name, "_cmd"}, cmd_exp, cur_cmd);
        end else if (chan == 0 && addr[3:0] == off_board_status) begin
            check_value({name, "_pwr"}, data[19], pwr_enable);
            check_value({name, "_amp"}, exp_dis, amp_disable);
        end else if (chan == 0 && addr[3:0] == off_dout_ctrl) begin
            check_value({name, "_dout"}, data[3:0], dout);
        end
    endtask

    // --------------------------------------
    // main sequence
    // --------------------------------------
    initial begin
        int          cnt;
        cur_vec_t    mid;
        cur_vec_t    quiet;
        cur_vec_t    fb;
        logic [31:0] r;
        cur_t        val;

        seed       = 19920;
        mid        = {num_axes{16'h8000}};
        cmd_exp    = mid;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        wenid      = board_wenid;
        cur_fb     = mid;

        repeat (8) @(posedge sysclk);
        #2 rst_n = 1'b1;
        next_cycle();

        check_value("rst_resp_valid", 0, resp_valid);
        check_value("rst_req_ready", 1, req_ready);
        check_value("rst_pwr_enable", 0, pwr_enable);
        check_value("rst_dout", 0, dout);
        check_value("rst_amp_disable", 4'hf, amp_disable);
        check_value("rst_cur_cmd", mid, cur_cmd);

        // dac write then readback per axis
        for (int a = 1; a <= num_axes; a++) begin
            val = $random(seed);
            add_entry($sformatf("dac_wr_ax%0d", a), 1, make_addr(a, off_dac_ctrl),
                      {16'h0000, val}, mid, 32'h0);
            add_entry($sformatf("dac_rd_ax%0d", a), 0, make_addr(a, off_dac_ctrl),
                      32'h0, mid, {16'h0000, val});
        end

        // feedback kept within the margin of midscale so nothing trips
        for (int a = 1; a <= num_axes; a++) begin
            r        = $random(seed);
            quiet[a] = r[16] ? cur_mid + r[7:0] : cur_mid - r[7:0];
        end
        for (int a = 1; a <= num_axes; a++)
            add_entry($sformatf("adc_rd_ax%0d", a), 0, make_addr(a, off_adc_data),
                      32'h0, quiet, {16'h0000, quiet[a]});

        // unused channels and offsets
        add_entry("rd_chan5", 0, make_addr(5, 4'd0), 32'h0, quiet, 32'h0);
        add_entry("rd_chan15", 0, make_addr(15, 4'd1), 32'h0, mid, 32'h0);
        add_entry("rd_ax1_off3", 0, make_addr(1, 4'd3), 32'h0, mid, 32'h0);
        add_entry("rd_chan0_off1", 0, make_addr(0, 4'd1), 32'h0, mid, 32'h0);

        // board channel
        add_entry("status_wr", 1, make_addr(0, off_board_status), 32'h0008_0005, mid, 32'h0);
        add_entry("status_rd", 0, make_addr(0, off_board_status), 32'h0,
                  mid, status_word(1'b1, 4'h0, 4'h5));
        add_entry("dout_wr", 1, make_addr(0, off_dout_ctrl), 32'h0000_000a, mid, 32'h0);
        add_entry("dout_rd", 0, make_addr(0, off_dout_ctrl), 32'h0, mid, 32'h0000_000a);
        add_entry("status_pwr_off", 1, make_addr(0, off_board_status), 32'h0000_000f,
                  mid, 32'h0);
        add_entry("status_rd_off", 0, make_addr(0, off_board_status), 32'h0,
                  mid, status_word(1'b0, 4'h0, 4'hf));

        for (int e = 0; e < names.size(); e++) begin
            cur_fb = fb_q[e];
            run_access(names[e], wr_q[e], addr_q[e], wdata_q[e], exp_q[e]);
            if (wr_q[e])
                check_write_effect(names[e], addr_q[e], wdata_q[e]);
        end

        // --------------------------------------
        // overcurrent trip on axis 2
        // --------------------------------------
        run_access("trip_enable_all", 1, make_addr(0, off_board_status), 32'h0008_000f, 32'h0);
        check_value("trip_amp_enabled", 4'h0, amp_disable);
        run_access("trip_cmd_ax2", 1, make_addr(2, off_dac_ctrl), 32'h0000_8100, 32'h0);
        fb     = mid;
        fb[2]  = 16'h9000;                            // 0x1000 > 2*0x100 + 0x100
        cur_fb = fb;
        cnt    = 0;
        while (!amp_disable[2]) begin
            next_cycle();
            cnt++;
            if (cnt > wait_limit)
                abort_run("axis 2 overcurrent never set its amplifier disable");
        end
        check_value("trip_amp_disable", 4'b0010, amp_disable);
        run_access("trip_status_rd", 0, make_addr(0, off_board_status), 32'h0,
                   status_word(1'b1, 4'b0010, 4'hf));

        // new command at zero current rearms the check
        cur_fb = mid;
        run_access("trip_clear_ax2", 1, make_addr(2, off_dac_ctrl), 32'h0000_8100, 32'h0);
        check_value("trip_cleared_amp", 4'h0, amp_disable);
        run_access("trip_clear_status", 0, make_addr(0, off_board_status), 32'h0,
                   status_word(1'b1, 4'h0, 4'hf));
        run_access("ax2_disable_wr", 1, make_addr(0, off_board_status), 32'h0008_000d, 32'h0);
        check_value("ax2_follows_enable", 4'b0010, amp_disable);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* source/qla_ctrl_top.sv */
// --------------------------------------
// motor controller register side: host bus port,
// board channel, axis commands and per-axis safety
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

module qla_ctrl_top import qla_pkg::*; #(
    parameter cur_t safety_margin = 16'h0100,  // added to 2x command
    parameter int   safety_hold   = 4          // cycles before trip
) (
    input  wire              sysclk,
    input  wire              rst_n,
    // host request / response
    input  wire              req_valid,
    input  wire bus_req_t    req,
    output logic             req_ready,
    output logic             resp_valid,
    output reg_data_t        resp_rdata,
    input  wire              resp_ready,
    // board i/o
    input  wire [3:0]        wenid,
    input  wire cur_vec_t    cur_fb,           // adc feedback, parallel
    output cur_vec_t         cur_cmd,          // dac command, parallel
    output axis_bits_t       amp_disable,
    output logic             pwr_enable,
    output logic [3:0]       dout
);

    // --------------------------------------
    // internal buses
    // --------------------------------------
    reg_wr_t    wr;                            // shared write bus
    reg_addr_t  rd_addr;
    reg_data_t  board_rdata;
    reg_data_t  dac_rdata;
    axis_bits_t trip;

    reg_bus_port bus_port_i (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .resp_ready  (resp_ready),
        .wr          (wr),
        .rd_addr     (rd_addr),
        .board_rdata (board_rdata),
        .dac_rdata   (dac_rdata),
        .cur_fb      (cur_fb)
    );

    // channel 0, board i/o
    board_regs chan0_i (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .wr          (wr),
        .rd_addr     (rd_addr),
        .board_rdata (board_rdata),
        .wenid       (wenid),
        .trip        (trip),
        .pwr_enable  (pwr_enable),
        .dout        (dout),
        .amp_disable (amp_disable)
    );

    dac_regs dac_i (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .dac_rdata (dac_rdata),
        .cur_cmd   (cur_cmd)
    );

    // --------------------------------------
    // safety check per axis
    // --------------------------------------
    for (genvar gi = 1; gi <= num_axes; gi++) begin : g_safety
        safety_check #(
            .axis          (gi),
            .safety_margin (safety_margin),
            .safety_hold   (safety_hold)
        ) safe_i (
            .sysclk       (sysclk),
            .rst_n        (rst_n),
            .wr           (wr),
            .cur_fb_axis  (cur_fb[gi]),
            .cur_cmd_axis (cur_cmd[gi]),
            .trip         (trip[gi])
        );
    end

endmodule

`default_nettype wire

/* source/safety_check.sv */
// --------------------------------------
// overcurrent check for one axis: trips when feedback
// exceeds twice the command plus a margin for a run of
// cycles, cleared by a new command write
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

module safety_check import qla_pkg::*; #(
    parameter int   axis          = 1,        // 1 to num_axes
    parameter cur_t safety_margin = 16'h0100,
    parameter int   safety_hold   = 4         // cycles over limit
) (
    input  wire              sysclk,
    input  wire              rst_n,
    input  wire reg_wr_t     wr,
    input  wire cur_t        cur_fb_axis,
    input  wire cur_t        cur_cmd_axis,
    output logic             trip
);

    localparam int cnt_w = $clog2(safety_hold + 1);

    cur_t             fb_mag;
    cur_t             cmd_mag;
    logic [17:0]      limit;                  // 2*cmd + margin, no overflow
    logic             over;
    logic             clr;
    logic [cnt_w-1:0] cnt;

    // distance from midscale
    assign fb_mag  = (cur_fb_axis >= cur_mid) ? cur_fb_axis - cur_mid
                                              : cur_mid - cur_fb_axis;
    assign cmd_mag = (cur_cmd_axis >= cur_mid) ? cur_cmd_axis - cur_mid
                                               : cur_mid - cur_cmd_axis;

    assign limit = {1'b0, cmd_mag, 1'b0} + {2'b00, safety_margin};
    assign over  = {2'b00, fb_mag} > limit;

    // new command on this axis rearms the check
    assign clr = wr.en && (addr_chan(wr.addr) == 4'(axis))
                       && (addr_off(wr.addr) == off_dac_ctrl);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            trip <= 1'b0;
        end else if (clr) begin
            cnt  <= '0;
            trip <= 1'b0;
        end else begin
            if (!over)
                cnt <= '0;                    // must be consecutive
            else if (cnt != cnt_w'(safety_hold))
                cnt <= cnt + 1'b1;            // saturates at hold
            if (cnt == cnt_w'(safety_hold))
                trip <= 1'b1;                 // latched
        end
    end

endmodule

`default_nettype wire

/* source/dac_regs.sv */
// --------------------------------------
// axis current command registers, one per axis,
// written at the dac offset of channels 1 to 4
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dac_regs import qla_pkg::*; (
    input  wire              sysclk,
    input  wire              rst_n,
    input  wire reg_wr_t     wr,
    input  wire reg_addr_t   rd_addr,
    output reg_data_t        dac_rdata,
    output cur_vec_t         cur_cmd      // parallel command out
);

    // write into the addressed axis slot
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cur_cmd <= {num_axes{cur_mid}};    // zero current
        end else if (wr.en && (addr_off(wr.addr) == off_dac_ctrl)) begin
            for (int a = 1; a <= num_axes; a++) begin
                if (addr_chan(wr.addr) == 4'(a))
                    cur_cmd[a] <= wr.data[15:0];
            end
        end
    end

    // readback of the addressed axis, channel 0 reads 0
    always_comb begin
        dac_rdata = '0;
        for (int a = 1; a <= num_axes; a++) begin
            if (addr_chan(rd_addr) == 4'(a))
                dac_rdata = {16'h0000, cur_cmd[a]};
        end
    end

endmodule

`default_nettype wire

/* source/board_regs.sv */
// --------------------------------------
// channel 0 board registers: status with board id,
// power and amplifier enables, digital outputs and
// the per-axis amplifier disable lines
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

module board_regs import qla_pkg::*; (
    input  wire              sysclk,
    input  wire              rst_n,
    input  wire reg_wr_t     wr,
    input  wire reg_addr_t   rd_addr,
    output reg_data_t        board_rdata,
    input  wire [3:0]        wenid,       // rotary switch, active low
    input  wire axis_bits_t  trip,        // latched safety trips
    output logic             pwr_enable,
    output logic [3:0]       dout,
    output axis_bits_t       amp_disable
);

    axis_bits_t amp_en;
    logic       wr_chan0;

    assign wr_chan0 = wr.en && (addr_chan(wr.addr) == chan_board);

    // --------------------------------------
    // channel 0 writes
    // --------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_enable <= 1'b0;
            amp_en     <= '0;
            dout       <= '0;
        end else if (wr_chan0) begin
            case (addr_off(wr.addr))
                off_board_status: begin
                    pwr_enable <= wr.data[19];
                    amp_en     <= wr.data[3:0];   // axis 1 in bit 0
                end
                off_dout_ctrl: dout <= wr.data[3:0];
                default: ;                        // other offsets ignored
            endcase
        end
    end

    // any of: not enabled, tripped, board power off
    assign amp_disable = ~amp_en | trip | {num_axes{~pwr_enable}};

    // --------------------------------------
    // readback
    // --------------------------------------
    always_comb begin
        case (addr_off(rd_addr))
            off_board_status: begin
                board_rdata = {
                    4'h0,
                    ~wenid,                   // board id
                    4'h0,
                    pwr_enable,               // bit 19
                    7'h00,
                    trip,                     // bits 11:8
                    4'h0,
                    amp_en                    // bits 3:0
                };
            end
            off_dout_ctrl: board_rdata = {28'h0, dout};
            default:       board_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/reg_bus_port.sv */
// --------------------------------------
// host side of the register bus: takes one valid/ready
// request, strobes the write bus, selects and holds the
// response word until the host takes it
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

module reg_bus_port import qla_pkg::*; (
    input  wire              sysclk,
    input  wire              rst_n,
    input  wire              req_valid,
    input  wire bus_req_t    req,
    output logic             req_ready,
    output logic             resp_valid,
    output reg_data_t        resp_rdata,
    input  wire              resp_ready,
    output reg_wr_t          wr,          // to all register blocks
    output reg_addr_t        rd_addr,
    input  wire reg_data_t   board_rdata,
    input  wire reg_data_t   dac_rdata,
    input  wire cur_vec_t    cur_fb
);

    bus_state_e state;
    bus_req_t   req_q;                    // captured request
    reg_data_t  rd_sel;                   // selected read word

    assign req_ready = (state == st_idle);
    assign rd_addr   = req_q.addr;

    // write strobe only while in access
    always_comb begin
        wr.en   = (state == st_access) && req_q.write;
        wr.addr = req_q.addr;
        wr.data = req_q.wdata;
    end

    // --------------------------------------
    // read decode by channel / offset
    // --------------------------------------
    always_comb begin
        rd_sel = '0;                      // unused channels read 0
        if (req_q.write) begin
            rd_sel = '0;                  // writes answer with 0
        end else if (addr_chan(rd_addr) == chan_board) begin
            rd_sel = board_rdata;
        end else begin
            for (int a = 1; a <= num_axes; a++) begin
                if (addr_chan(rd_addr) == 4'(a)) begin
                    case (addr_off(rd_addr))
                        off_dac_ctrl: rd_sel = dac_rdata;
                        off_adc_data: rd_sel = {16'h0000, cur_fb[a]};
                        default:      rd_sel = '0;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (req_valid && req_ready)
            req_q <= req;                 // payload, held until next accept
    end

    // --------------------------------------
    // request / response FSM
    // --------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            resp_valid <= 1'b0;
            resp_rdata <= '0;
        end else begin
            case (state)
                st_idle: if (req_valid) state <= st_access;
                st_access: state <= st_respond;   // write lands here
                st_respond: begin
                    if (!resp_valid) begin
                        resp_valid <= 1'b1;       // data sees the write
                        resp_rdata <= rd_sel;
                    end else if (resp_ready) begin
                        resp_valid <= 1'b0;
                        state      <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/qla_pkg.sv */
// --------------------------------------
// shared types for the motor controller register bus:
// address map, offsets, bus structs and FSM states
// import with qla_pkg::* in the module header
// --------------------------------------
`default_nettype none

package qla_pkg;

    // --------------------------------------
    // sizes and basic words
    // --------------------------------------
    localparam int num_axes = 4;          // fixed by channel addressing

    typedef logic [15:0] reg_addr_t;      // [7:4] channel, [3:0] offset
    typedef logic [31:0] reg_data_t;
    typedef logic [15:0] cur_t;           // offset binary, 0x8000 = zero amps

    typedef cur_t [num_axes:1] cur_vec_t;         // axis 1 in lowest slot
    typedef logic [num_axes:1] axis_bits_t;       // one bit per axis

    localparam cur_t       cur_mid    = 16'h8000; // midscale
    localparam logic [3:0] chan_board = 4'd0;     // board i/o channel

    // --------------------------------------
    // register offsets within a channel
    // --------------------------------------
    typedef enum logic [3:0] {
        off_adc_data  = 4'd0,             // axis: current feedback
        off_dac_ctrl  = 4'd1,             // axis: current command
        off_dout_ctrl = 4'd2              // board: digital outputs
    } reg_offset_e;

    // board status shares offset 0 with adc data on the axis channels
    localparam reg_offset_e off_board_status = off_adc_data;

    // host request, one access at a time
    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        reg_data_t wdata;
    } bus_req_t;

    // write bus broadcast to all register blocks
    typedef struct packed {
        logic      en;                    // single cycle strobe
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_respond
    } bus_state_e;

    // address field helpers
    function automatic logic [3:0] addr_chan(reg_addr_t addr);
        return addr[7:4];
    endfunction

    function automatic reg_offset_e addr_off(reg_addr_t addr);
        return reg_offset_e'(addr[3:0]);
    endfunction

endpackage

`default_nettype wire
